// ==== rtl/agnus_settings.svh ====
// widths and addresses are fixed for OCS Agnus; register addresses are bits 8..1 of the byte offset
`ifndef AGNUS_SETTINGS_SVH
`define AGNUS_SETTINGS_SVH

// ----------------------------------------
// bus widths
// ----------------------------------------
`define CHIP_AW       20      // chip address, bits 20..1
`define REG_AW        8       // register address, bits 8..1
`define DATA_W        16      // data bus

// ----------------------------------------
// register addresses (byte offset >> 1)
// ----------------------------------------
`define REG_IDLE      8'hff   // no register selected
`define REG_DMACON    8'h4b   // DMACON, byte offset 096h
`define REG_DMACONR   8'h01   // DMACONR, byte offset 002h

// ----------------------------------------
// DMACON layout
// ----------------------------------------
`define DMACON_W      13      // stored control bits 12..0
`define DMACON_SETCLR 15      // 1 sets, 0 clears the written bits
`define DMAEN_BIT     9       // master enable
`define BPLEN_BIT     8
`define COPEN_BIT     7
`define BLTEN_BIT     6
`define SPREN_BIT     5
`define BLTPRI_BIT    10      // blitter nasty

`define BLS_CNT_W     2       // slowdown counter width
`define BLS_CNT_MAX   2'd3    // missed CPU cycles before the blitter is held off

`endif

// ==== rtl/agnus_pkg.sv ====
// bundle types for the arbiter; layouts follow the macro widths and must match the testbench
`include "agnus_settings.svh"

package agnus_pkg;

  // ----------------------------------------
  // one DMA channel's address pair
  // ----------------------------------------
  typedef struct packed {
    logic [`CHIP_AW:1] address;     // chip ram word address
    logic [`REG_AW:1]  reg_address; // custom register the fetched word goes to
  } chan_bus_t;

  // enables derived from DMACON, master enable already folded in
  typedef struct packed {
    logic bltpri;  // blitter nasty, taken straight from dmacon
    logic bplen;   // bitplane
    logic copen;   // copper
    logic blten;   // blitter
    logic spren;   // sprites
  } dma_enable_t;

  // chip bus ownership and the request acknowledges
  typedef struct packed {
    logic cpu_custom; // cpu owns chip ram and registers
    logic dbr;        // agnus holds the data bus
    logic dbwe;       // dma write cycle, disk or blitter only
    logic ack_spr;
    logic ack_cop;
    logic ack_blt;
  } bus_grant_t;

  // blitter status, read back in DMACONR
  typedef struct packed {
    logic blit_busy;
    logic blit_zero;
  } blit_status_t;

endpackage

// ==== rtl/dma_control_decode.sv ====
// DMACON is written on any cycle whose bus register address hits it; hwr/lwr only qualify the cpu decode
`timescale 1ns/100ps
`include "agnus_settings.svh"

module dma_control_decode (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       clk7_en,         // 7 MHz bus clock enable
  input  logic                       aen,             // register bank selected
  input  logic                       rd,
  input  logic                       hwr,
  input  logic                       lwr,
  input  logic [`REG_AW:1]           address_in,      // cpu register address
  input  logic [`DATA_W-1:0]         data_in,
  input  logic [`REG_AW:1]           reg_address,     // register address on the bus
  output logic [`REG_AW:1]           cpu_reg_address,
  output logic [`DMACON_W-1:0]       dmacon,
  output agnus_pkg::dma_enable_t     dma_en
);

  // ----------------------------------------
  // cpu register address decode
  // ----------------------------------------
  logic cpu_access;  // cpu drives a register cycle

  assign cpu_access = aen & (rd | hwr | lwr);

  // idle address keeps every register decoder quiet
  assign cpu_reg_address = cpu_access ? address_in : `REG_IDLE;

  // ----------------------------------------
  // DMACON register
  // ----------------------------------------
  logic dmacon_hit;  // bus addresses DMACON this cycle
  logic set_clr;     // write polarity

  assign dmacon_hit = (reg_address == `REG_DMACON);
  assign set_clr    = data_in[`DMACON_SETCLR];

  always_ff @(posedge clk) begin
    if (reset) begin
      dmacon <= '0;                                       // all channels off
    end else if (clk7_en && dmacon_hit) begin
      if (set_clr)
        dmacon <= dmacon | data_in[`DMACON_W-1:0];        // set the ones
      else
        dmacon <= dmacon & ~data_in[`DMACON_W-1:0];       // clear the ones
    end
  end

  // ----------------------------------------
  // enable levels for the engines
  // ----------------------------------------
  logic dmaen;  // master enable

  assign dmaen = dmacon[`DMAEN_BIT];

  always_comb begin
    dma_en.bltpri = dmacon[`BLTPRI_BIT];                  // not gated by master
    dma_en.bplen  = dmacon[`BPLEN_BIT] & dmaen;
    dma_en.copen  = dmacon[`COPEN_BIT] & dmaen;
    dma_en.blten  = dmacon[`BLTEN_BIT] & dmaen;
    dma_en.spren  = dmacon[`SPREN_BIT] & dmaen;
  end

  // every engine must see itself disabled right after reset
  a_dmacon_reset: assert property (
    @(posedge clk) reset |=> (dmacon == '0)
  ) else $error("dmacon not cleared after reset");

endmodule

// ==== rtl/bus_priority_execute.sv ====
// fixed priority, no fairness; slot allocation is done by the engines, only their requests arrive here
`timescale 1ns/100ps
`include "agnus_settings.svh"

module bus_priority_execute (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    clk7_en,
  input  logic                    cck,             // colour clock, high on chipset slots
  input  logic                    turbo,           // blitter may take every slot
  input  logic                    bls,             // cpu is waiting for the bus
  input  agnus_pkg::dma_enable_t  dma_en,
  input  logic [`REG_AW:1]        cpu_reg_address,
  input  logic                    dma_dsk,         // disk uses its slot
  input  logic                    wr_dsk,          // disk writes chip ram
  input  agnus_pkg::chan_bus_t    dsk_bus,
  input  logic                    dma_ref,         // refresh slot
  input  logic                    dma_aud,
  input  agnus_pkg::chan_bus_t    aud_bus,
  input  logic                    dma_bpl,
  input  logic                    ddf,             // bitplane data fetch window
  input  agnus_pkg::chan_bus_t    bpl_bus,
  input  logic                    req_spr,
  input  agnus_pkg::chan_bus_t    spr_bus,
  input  logic                    req_cop,
  input  agnus_pkg::chan_bus_t    cop_bus,
  input  logic                    req_blt,
  input  logic                    we_blt,          // blitter writes chip ram
  input  agnus_pkg::chan_bus_t    blt_bus,
  output agnus_pkg::bus_grant_t   grant,
  output logic [`CHIP_AW:1]       address_out,
  output logic [`REG_AW:1]        reg_address,
  output logic                    ena_cop,
  output logic                    blt_enadma
);

  // ----------------------------------------
  // request qualification
  // ----------------------------------------
  logic dma_spr;    // sprite wants and may use the slot
  logic dma_cop;
  logic dma_blt;
  logic bls_open;   // slowdown lets the blitter in
  logic higher;     // any channel above the blitter active

  logic [`BLS_CNT_W-1:0] bls_cnt;  // cpu misses in a row

  // sprites may not steal a slot inside the fetch window
  assign dma_spr  = req_spr & dma_en.spren & ~(ddf & dma_en.bplen);
  assign dma_cop  = req_cop & dma_en.copen;
  assign dma_blt  = req_blt & dma_en.blten;
  assign bls_open = (bls_cnt != `BLS_CNT_MAX);

  assign higher = dma_dsk | dma_ref | dma_aud | dma_bpl | dma_spr | dma_cop;

  // ----------------------------------------
  // priority mux, first match wins
  // ----------------------------------------
  always_comb begin
    grant       = '0;
    address_out = '0;
    reg_address = cpu_reg_address;                 // cpu by default
    if (dma_dsk) begin
      grant.dbr   = 1'b1;
      grant.dbwe  = wr_dsk;                        // disk may write
      address_out = dsk_bus.address;
      reg_address = dsk_bus.reg_address;
    end else if (dma_ref) begin
      grant.dbr   = 1'b1;                          // address stays 0
      reg_address = `REG_IDLE;
    end else if (dma_aud) begin
      grant.dbr   = 1'b1;
      address_out = aud_bus.address;
      reg_address = aud_bus.reg_address;
    end else if (dma_bpl) begin
      grant.dbr   = 1'b1;
      address_out = bpl_bus.address;
      reg_address = bpl_bus.reg_address;
    end else if (dma_spr) begin
      grant.dbr     = 1'b1;
      grant.ack_spr = 1'b1;
      address_out   = spr_bus.address;
      reg_address   = spr_bus.reg_address;
    end else if (dma_cop) begin
      grant.dbr     = 1'b1;
      grant.ack_cop = 1'b1;
      address_out   = cop_bus.address;
      reg_address   = cop_bus.reg_address;
    end else if (dma_blt && bls_open) begin
      grant.dbr     = 1'b1;
      grant.ack_blt = 1'b1;
      grant.dbwe    = we_blt;                      // blitter may write
      address_out   = blt_bus.address;
      reg_address   = blt_bus.reg_address;
    end else begin
      grant.cpu_custom = 1'b1;                     // nobody else wants it
    end
  end

  // copper slots can only be taken by bitplanes above it
  assign ena_cop = ~dma_bpl;

  // blitter runs in any free slot unless the cpu is starving
  assign blt_enadma = dma_en.blten & ~higher & bls_open;

  // ----------------------------------------
  // blitter slowdown counter
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      bls_cnt <= '0;
    end else if (clk7_en && (!cck || turbo)) begin  // counts memory cycles only
      if (!bls || dma_en.bltpri)
        bls_cnt <= '0;                              // cpu got through, or nasty mode
      else if (bls_open)
        bls_cnt <= bls_cnt + 1'b1;                  // saturates at the limit
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_one_ack: assert property (
    @(posedge clk) disable iff (reset)
      $onehot0({grant.ack_spr, grant.ack_cop, grant.ack_blt})
  ) else $error("more than one dma acknowledge");

  a_dbwe_dbr: assert property (
    @(posedge clk) disable iff (reset) grant.dbwe |-> grant.dbr
  ) else $error("dma write without bus ownership");

endmodule

// ==== rtl/chip_bus_result.sv ====
// data_out is an OR merge, so every other source must drive zero when not addressed
`timescale 1ns/100ps
`include "agnus_settings.svh"

module chip_bus_result (
  input  logic [`REG_AW:1]        reg_address,  // register address on the bus
  input  logic [`DMACON_W-1:0]    dmacon,
  input  agnus_pkg::blit_status_t blit_status,
  input  logic [`DATA_W-1:0]      data_blt,     // blitter register read data
  output logic [`DATA_W-1:0]      data_out
);

  // ----------------------------------------
  // DMACONR read-back
  // ----------------------------------------
  logic                dmaconr_hit;
  logic [`DATA_W-1:0]  dmaconr;      // zero unless addressed

  assign dmaconr_hit = (reg_address == `REG_DMACONR);

  always_comb begin
    if (dmaconr_hit) begin
      // bit 15 reads 0, status flags above the stored bits
      dmaconr = {1'b0,
                 blit_status.blit_busy,
                 blit_status.blit_zero,
                 dmacon};
    end else begin
      dmaconr = '0;
    end
  end

  // ----------------------------------------
  // merge onto the read bus
  // ----------------------------------------
  assign data_out = dmaconr | data_blt;

endmodule

// ==== rtl/agnus_dma_arbiter.sv ====
// chip-bus arbitration core only; DMA engines, beam counter and refresh slots live outside
`timescale 1ns/100ps
`include "agnus_settings.svh"

module agnus_dma_arbiter (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    clk7_en,
  input  logic                    cck,
  input  logic                    turbo,
  input  logic                    bls,
  // cpu bus
  input  logic                    aen,
  input  logic                    rd,
  input  logic                    hwr,
  input  logic                    lwr,
  input  logic [`REG_AW:1]        address_in,
  input  logic [`DATA_W-1:0]      data_in,
  // dma channels
  input  logic                    dma_dsk,
  input  logic                    wr_dsk,
  input  agnus_pkg::chan_bus_t    dsk_bus,
  input  logic                    dma_ref,
  input  logic                    dma_aud,
  input  agnus_pkg::chan_bus_t    aud_bus,
  input  logic                    dma_bpl,
  input  logic                    ddf,
  input  agnus_pkg::chan_bus_t    bpl_bus,
  input  logic                    req_spr,
  input  agnus_pkg::chan_bus_t    spr_bus,
  input  logic                    req_cop,
  input  agnus_pkg::chan_bus_t    cop_bus,
  input  logic                    req_blt,
  input  agnus_pkg::chan_bus_t    blt_bus,
  input  logic                    we_blt,
  input  logic [`DATA_W-1:0]      data_blt,
  input  agnus_pkg::blit_status_t blit_status,
  // chip bus
  output logic [`CHIP_AW:1]       address_out,
  output logic [`REG_AW:1]        reg_address_out,
  output logic [`DATA_W-1:0]      data_out,
  output agnus_pkg::bus_grant_t   grant,
  output logic                    ena_cop,
  output logic                    blt_enadma,
  output agnus_pkg::dma_enable_t  dma_en
);

  // ----------------------------------------
  // stage wiring
  // ----------------------------------------
  logic [`REG_AW:1]     cpu_reg_address;  // decode -> execute
  logic [`DMACON_W-1:0] dmacon;           // decode -> result

  dma_control_decode decode_i (
    .clk, .reset, .clk7_en, .aen, .rd, .hwr, .lwr, .address_in, .data_in,
    .reg_address     (reg_address_out),   // bus address feeds the register write
    .cpu_reg_address, .dmacon, .dma_en
  );

  bus_priority_execute execute_i (
    .clk, .reset, .clk7_en, .cck, .turbo, .bls, .dma_en, .cpu_reg_address,
    .dma_dsk, .wr_dsk, .dsk_bus, .dma_ref, .dma_aud, .aud_bus,
    .dma_bpl, .ddf, .bpl_bus, .req_spr, .spr_bus, .req_cop, .cop_bus,
    .req_blt, .we_blt, .blt_bus,
    .grant, .address_out,
    .reg_address     (reg_address_out),
    .ena_cop, .blt_enadma
  );

  chip_bus_result result_i (
    .reg_address     (reg_address_out),
    .dmacon, .blit_status, .data_blt, .data_out
  );

endmodule

// ==== sim/agnus_tb.sv ====
// reads sim/agnus_arbiter_golden.txt from the project root; clk7_en held high, turbo held low
`timescale 1ns/100ps
`include "agnus_settings.svh"

module agnus_tb;

  // ----------------------------------------
  // dut ports
  // ----------------------------------------
  logic clk = 1'b0;
  logic reset, clk7_en, cck, turbo, bls;
  logic aen, rd, hwr, lwr;
  logic [`REG_AW:1]   address_in;
  logic [`DATA_W-1:0] data_in, data_blt, data_out;
  logic dma_dsk, wr_dsk, dma_ref, dma_aud, dma_bpl, ddf;
  logic req_spr, req_cop, req_blt, we_blt;
  agnus_pkg::chan_bus_t    dsk_bus, aud_bus, bpl_bus, spr_bus, cop_bus, blt_bus;
  agnus_pkg::blit_status_t blit_status;
  logic [`CHIP_AW:1]       address_out;
  logic [`REG_AW:1]        reg_address_out;
  agnus_pkg::bus_grant_t   grant;
  logic                    ena_cop, blt_enadma;
  agnus_pkg::dma_enable_t  dma_en;

  // ----------------------------------------
  // vector store and bookkeeping
  // ----------------------------------------
  int              vecs [64][23];    // fields after the name, golden column order
  logic [8*16-1:0] names [64];
  logic [8*16-1:0] cur_name;         // test the current vector belongs to
  int              n_vec = 0;
  int              cycles = 0;
  int              cycle_limit = 1000;  // tightened once the vectors are known
  int              test_errors = 0, total_errors = 0, tests_run = 0, tests_failed = 0;
  logic [31:0]     lcg_state;

  // reference state, stepped once per vector like the DUT's clock edge
  logic [`DMACON_W-1:0] dmacon_ref;  // control bits as written so far
  int                   bls_ref;     // cpu misses in a row, saturating

  agnus_dma_arbiter dut_i (.*);

  always #50 clk = ~clk;  // 100 ns period

  // run guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [`CHIP_AW:1] rand_address();
    lcg_state = lcg_next(lcg_state);
    return lcg_state[31:12];  // upper bits, better spread
  endfunction

  // winner codes as in the golden header
  function automatic logic [`CHIP_AW:1] expected_address(input int win);
    case (win)
      1:       return dsk_bus.address;
      3:       return aud_bus.address;
      4:       return bpl_bus.address;
      5:       return spr_bus.address;
      6:       return cop_bus.address;
      7:       return blt_bus.address;
      default: return '0;  // cpu and refresh drive 0
    endcase
  endfunction

  // channel bits count only with the master enable, bltpri always
  function automatic agnus_pkg::dma_enable_t expected_enables();
    agnus_pkg::dma_enable_t e;
    logic                   master;
    master   = dmacon_ref[`DMAEN_BIT];
    e.bltpri = dmacon_ref[`BLTPRI_BIT];
    e.bplen  = dmacon_ref[`BPLEN_BIT] & master;
    e.copen  = dmacon_ref[`COPEN_BIT] & master;
    e.blten  = dmacon_ref[`BLTEN_BIT] & master;
    e.spren  = dmacon_ref[`SPREN_BIT] & master;
    return e;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("[FAIL] %0t ns %0s %0s: got %h, expected %h", $time, cur_name, what, got, want);
      test_errors++;
    end
  endtask

  task automatic init_inputs();
    reset = 1'b1;
    clk7_en = 1'b1;    // every clk edge is a bus cycle
    {cck, turbo, bls, aen, rd, hwr, lwr} = '0;
    {address_in, data_in, data_blt} = '0;
    {dma_dsk, wr_dsk, dma_ref, dma_aud, dma_bpl, ddf} = '0;
    {req_spr, req_cop, req_blt, we_blt} = '0;
    {dsk_bus, aud_bus, bpl_bus, spr_bus, cop_bus, blt_bus} = '0;
    blit_status = '0;
    lcg_state = 32'hb9bb4339;
    dmacon_ref = '0;   // reset clears every enable
    bls_ref = 0;
  endtask

  task automatic load_vectors();
    int              fd;
    int              cnt;
    logic [8*160-1:0] line;
    logic [8*16-1:0] nm;
    int              fld [23];
    fd = $fopen("sim/agnus_arbiter_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open golden file sim/agnus_arbiter_golden.txt");
    end else begin
      while ($fgets(line, fd) > 0 && n_vec < 64) begin
        cnt = $sscanf(line,
          "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          nm, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
          fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15],
          fld[16], fld[17], fld[18], fld[19], fld[20], fld[21], fld[22]);
        if (cnt == 24) begin          // header lines never parse this far
          names[n_vec] = nm;
          for (int k = 0; k < 23; k++)
            vecs[n_vec][k] = fld[k];
          n_vec++;
        end
      end
      $fclose(fd);
      if (n_vec == 0)
        $display("golden file holds no usable vectors");
    end
  endtask

  task automatic apply_inputs(input int i);
    aen         = vecs[i][0][0];
    rd          = vecs[i][1][0];
    hwr         = vecs[i][2][0];      // word write, both halves
    lwr         = vecs[i][2][0];
    address_in  = vecs[i][3][7:0];
    data_in     = vecs[i][4][15:0];
    cck         = vecs[i][5][0];
    bls         = vecs[i][6][0];
    dma_dsk     = vecs[i][7][0];
    wr_dsk      = vecs[i][8][0];
    dma_ref     = vecs[i][9][0];
    dma_aud     = vecs[i][10][0];
    dma_bpl     = vecs[i][11][0];
    ddf         = vecs[i][12][0];
    req_spr     = vecs[i][13][0];
    req_cop     = vecs[i][14][0];
    req_blt     = vecs[i][15][0];
    we_blt      = vecs[i][16][0];
    blit_status = vecs[i][17][1:0];
    data_blt    = vecs[i][18][15:0];
    // fresh chip addresses every cycle, fixed register targets
    dsk_bus = {rand_address(), 8'h13};
    aud_bus = {rand_address(), 8'h55};
    bpl_bus = {rand_address(), 8'h88};
    spr_bus = {rand_address(), 8'ha2};
    cop_bus = {rand_address(), 8'h46};
    blt_bus = {rand_address(), 8'h3b};
  endtask

  // ----------------------------------------
  // reference state for the clock edge inside vector i
  // ----------------------------------------
  task automatic step_reference(input int i);
    logic [`DATA_W-1:0] wdata;
    wdata = vecs[i][4][15:0];
    // slowdown sees bltpri from before this edge
    if (vecs[i][5][0] == 1'b0) begin              // memory cycle, turbo off
      if (vecs[i][6][0] == 1'b0 || dmacon_ref[`BLTPRI_BIT])
        bls_ref = 0;                              // cpu got the bus or nasty mode
      else if (bls_ref < `BLS_CNT_MAX)
        bls_ref++;
    end
    if (vecs[i][20] == `REG_DMACON) begin         // bus addresses DMACON
      if (wdata[`DMACON_SETCLR])
        dmacon_ref = dmacon_ref | wdata[`DMACON_W-1:0];
      else
        dmacon_ref = dmacon_ref & ~wdata[`DMACON_W-1:0];
    end
  endtask

  task automatic compare_outputs(input int i);
    agnus_pkg::dma_enable_t en;
    logic                   blt_free;
    en = expected_enables();
    // cpu or blitter winning means no channel above the blitter is active
    blt_free = (vecs[i][19] == 0) || (vecs[i][19] == 7);
    check_value("address_out", 32'(address_out), 32'(expected_address(vecs[i][19])));
    check_value("reg_address_out", 32'(reg_address_out), vecs[i][20]);
    check_value("data_out", 32'(data_out), vecs[i][21]);
    check_value("grant", 32'(grant), vecs[i][22]);
    check_value("dma_en", 32'(dma_en), 32'(en));
    check_value("ena_cop", 32'(ena_cop), 32'(!vecs[i][11][0]));  // bitplanes block copper
    check_value("blt_enadma", 32'(blt_enadma),
                32'(blt_free && en.blten && (bls_ref < `BLS_CNT_MAX)));
  endtask

  task automatic close_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0s: ok", cur_name);
    end else begin
      $display("test %0s: %0d mismatches", cur_name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    init_inputs();
    load_vectors();
    if (n_vec == 0) begin
      $display("Test failed");
      $finish;
    end else begin
      cycle_limit = 2 * n_vec + 20;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      cur_name = names[0];
      for (int i = 0; i < n_vec; i++) begin
        if (names[i] != cur_name) begin
          close_test();
          cur_name = names[i];
        end
        apply_inputs(i);           // on the falling edge
        @(posedge clk);
        #40;                       // 10 ns before the next falling edge
        step_reference(i);
        compare_outputs(i);
        @(negedge clk);
      end
      close_test();
      $display("tests: %0d, failing: %0d, mismatches: %0d", tests_run, tests_failed,
               total_errors);
      if (total_errors == 0)
        $display("Test passed");
      else
        $display("Test failed");
      $finish;
    end
  end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/agnus_pkg.sv
rtl/dma_control_decode.sv
rtl/bus_priority_execute.sv
rtl/chip_bus_result.sv
rtl/agnus_dma_arbiter.sv
sim/agnus_tb.sv

// ==== Makefile ====
# Verilator flow for the agnus arbiter; run from the project root
VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= agnus_tb
RTL_TOP   ?= agnus_dma_arbiter
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# status comes from grep, so a missing pass line fails the target
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/agnus_arbiter_golden.txt ====
# name aen rd wr addr data cck bls dsk wdsk ref aud bpl ddf spr cop blt wblt stat dblt win xreg xdata xgnt
# win 0 cpu 1 dsk 2 ref 3 aud 4 bpl 5 spr 6 cop 7 blt, regs dsk 13 aud 55 bpl 88 spr a2 cop 46 blt 3b
cpu_decode   0 0 0 00 0000 1 0 0 0 0 0 0 0 0 0 0 0 0 0000 0 ff 0000 20
cpu_decode   0 1 0 12 0000 1 0 0 0 0 0 0 0 0 0 0 0 0 0000 0 ff 0000 20
cpu_decode   1 1 0 12 0000 1 0 0 0 0 0 0 0 0 0 0 0 0 0000 0 12 0000 20
cpu_decode   1 0 0 34 0000 1 0 0 0 0 0 0 0 0 0 0 0 0 0000 0 ff 0000 20
cpu_decode   1 0 1 20 0000 1 0 0 0 0 0 0 0 0 0 0 0 0 0000 0 20 0000 20
dmacon       0 0 0 00 0000 1 0 0 0 0 0 0 0 0 1 0 0 0 0000 0 ff 0000 20
dmacon       1 0 1 4b 8080 1 0 0 0 0 0 0 0 0 0 0 0 0 0000 0 4b 0000 20
dmacon       0 0 0 00 0000 1 0 0 0 0 0 0 0 0 1 0 0 0 0000 0 ff 0000 20
dmacon       1 0 1 4b 8200 1 0 0 0 0 0 0 0 0 0 0 0 0 0000 0 4b 0000 20
dmacon       0 0 0 00 0000 1 0 0 0 0 0 0 0 0 1 0 0 0 0000 6 46 0000 12
dmacon       1 0 1 4b 0080 1 0 0 0 0 0 0 0 0 0 0 0 0 0000 0 4b 0000 20
dmacon       0 0 0 00 0000 1 0 0 0 0 0 0 0 0 1 0 0 0 0000 0 ff 0000 20
dmaconr      1 0 1 4b 81e0 1 0 0 0 0 0 0 0 0 0 0 0 0 0000 0 4b 0000 20
dmaconr      1 1 0 01 0000 1 0 0 0 0 0 0 0 0 0 0 0 0 0000 0 01 03e0 20
dmaconr      1 1 0 01 0000 1 0 0 0 0 0 0 0 0 0 0 0 3 0000 0 01 63e0 20
dmaconr      1 1 0 01 0000 1 0 0 0 0 0 0 0 0 0 0 0 2 0005 0 01 43e5 20
dmaconr      0 0 0 00 0000 1 0 0 0 0 0 0 0 0 0 0 0 3 1234 0 ff 1234 20
priority     0 0 0 00 0000 1 0 1 1 1 1 1 0 1 1 1 1 0 0000 1 13 0000 18
priority     0 0 0 00 0000 1 0 0 1 1 1 1 0 1 1 1 1 0 0000 2 ff 0000 10
priority     0 0 0 00 0000 1 0 0 1 0 1 1 0 1 1 1 1 0 0000 3 55 0000 10
priority     0 0 0 00 0000 1 0 0 1 0 0 1 0 1 1 1 1 0 0000 4 88 0000 10
priority     0 0 0 00 0000 1 0 0 1 0 0 0 0 1 1 1 1 0 0000 5 a2 0000 14
priority     0 0 0 00 0000 1 0 0 1 0 0 0 0 0 1 1 1 0 0000 6 46 0000 12
priority     0 0 0 00 0000 1 0 0 1 0 0 0 0 0 0 1 1 0 0000 7 3b 0000 19
priority     0 0 0 00 0000 1 0 0 1 0 0 0 0 0 0 0 1 0 0000 0 ff 0000 20
sprite_block 0 0 0 00 0000 1 0 0 0 0 0 0 1 1 0 0 0 0 0000 0 ff 0000 20
sprite_block 0 0 0 00 0000 1 0 0 0 0 0 0 0 1 0 0 0 0 0000 5 a2 0000 14
sprite_block 0 0 0 00 0000 1 0 0 0 0 0 0 1 1 1 0 0 0 0000 6 46 0000 12
slowdown     0 0 0 00 0000 0 1 0 0 0 0 0 0 0 0 1 0 0 0000 7 3b 0000 11
slowdown     0 0 0 00 0000 0 1 0 0 0 0 0 0 0 0 1 0 0 0000 7 3b 0000 11
slowdown     0 0 0 00 0000 0 1 0 0 0 0 0 0 0 0 1 0 0 0000 0 ff 0000 20
slowdown     0 0 0 00 0000 0 1 0 0 0 0 0 0 0 0 1 0 0 0000 0 ff 0000 20
slowdown     0 0 0 00 0000 0 0 0 0 0 0 0 0 0 0 1 0 0 0000 7 3b 0000 11
slowdown     0 0 0 00 0000 1 1 0 0 0 0 0 0 0 0 1 0 0 0000 7 3b 0000 11
slowdown     1 0 1 4b 8400 1 0 0 0 0 0 0 0 0 0 0 0 0 0000 0 4b 0000 20
slowdown     0 0 0 00 0000 0 1 0 0 0 0 0 0 0 0 1 0 0 0000 7 3b 0000 11
slowdown     0 0 0 00 0000 0 1 0 0 0 0 0 0 0 0 1 0 0 0000 7 3b 0000 11
slowdown     0 0 0 00 0000 0 1 0 0 0 0 0 0 0 0 1 0 0 0000 7 3b 0000 11
